// ==== verilog.f ====
verilog/cpu_pkg.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/status_flags.sv
verilog/bus_master.sv
verilog/cpu_control.sv
verilog/cpu_top.sv
testbench/bus_memory.sv
testbench/cpu_tb.sv

// ==== testbench/program_vectors.txt ====
# P address data : memory preload word
# W address data : expected bus write, in order
P FFFFFFF0 00000100
P 00002000 7FFFFFFF
P 00000100 00050108
P 00000104 FFFD0208
P 00000108 00021301
P 0000010C 1000030A
P 00000110 00021402
P 00000114 1004040A
P 00000118 00021503
P 0000011C 1008050A
P 00000120 00021604
P 00000124 100C060A
P 00000128 00021705
P 0000012C 1010070A
P 00000130 7FF01807
P 00000134 1014080A
P 00000138 00011007
P 0000013C 1018000A
P 00000140 10100909
P 00000144 101C090A
P 00000148 20000B09
P 0000014C 00550A08
P 00000150 00011006
P 00000154 000400F0
P 00000158 11000A0A
P 0000015C 000400D0
P 00000160 11040A0A
P 00000164 00040090
P 00000168 11080A0A
P 0000016C 00040013
P 00000170 110C0A0A
P 00000174 00040033
P 00000178 11100A0A
P 0000017C 000400D3
P 00000180 11140A0A
P 00000184 00012006
P 00000188 00040030
P 0000018C 11180A0A
P 00000190 00040010
P 00000194 111C0A0A
P 00000198 000400B3
P 0000019C 11200A0A
P 000001A0 00040093
P 000001A4 11240A0A
P 000001A8 000400B0
P 000001AC 11280A0A
P 000001B0 00040013
P 000001B4 112C0A0A
P 000001B8 0001BC01
P 000001BC 10200C0A
P 000001C0 00040070
P 000001C4 11300A0A
P 000001C8 00040050
P 000001CC 11340A0A
P 000001D0 000400D3
P 000001D4 11380A0A
P 000001D8 000400F3
P 000001DC 113C0A0A
P 000001E0 00040080
P 000001E4 11400A0A
P 000001E8 00040082
P 000001EC 11440A0A
P 000001F0 00040053
P 000001F4 11480A0A
P 000001F8 FFFC0080
W 00001000 00000002
W 00001004 00000008
W 00001008 00000005
W 0000100C FFFFFFFD
W 00001010 FFFFFFF8
W 00001014 00007FF5
W 00001018 00000000
W 0000101C FFFFFFF8
W 00001104 00000055
W 00001108 00000055
W 0000110C 00000055
W 00001114 00000055
W 0000111C 00000055
W 00001124 00000055
W 00001020 80000004
W 00001134 00000055
W 0000113C 00000055
W 00001148 00000055

// ==== testbench/cpu_tb.sv ====
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

timeunit 1ns;
timeprecision 100ps;

localparam int WAIT_LIMIT = 500;	// cycles allowed between writes

logic clk;
logic rst_i;
logic cpu_cyc, cpu_stb, cpu_we, mem_ack;
sel_t cpu_sel;
word_t cpu_adr, cpu_wdat, mem_rdat;
logic wr_valid;
word_t wr_adr, wr_dat;
sel_t wr_sel;

word_t exp_adr [$];
word_t exp_dat [$];

cpu_top UUT (
	.clk(clk), .rst_i(rst_i), .cyc_o(cpu_cyc), .stb_o(cpu_stb), .we_o(cpu_we),
	.sel_o(cpu_sel), .adr_o(cpu_adr), .dat_o(cpu_wdat),
	.ack_i(mem_ack), .dat_i(mem_rdat)
);

bus_memory u_mem (
	.clk(clk), .cyc_i(cpu_cyc), .stb_i(cpu_stb), .we_i(cpu_we), .sel_i(cpu_sel),
	.adr_i(cpu_adr), .dat_i(cpu_wdat), .ack_o(mem_ack), .dat_o(mem_rdat),
	.wr_valid_o(wr_valid), .wr_adr_o(wr_adr), .wr_dat_o(wr_dat), .wr_sel_o(wr_sel)
);

always #2 clk = ~clk;

// ------------------------------------------------------------
// helpers
// ------------------------------------------------------------
task automatic check_word(input string name, input word_t exp, input word_t act);
	assert (exp === act) else begin
		$display("[FAIL] %s expected %08h actual %08h", name, exp, act);
		$display("ERRORS FOUND");
		$fatal(1, "stopping at first mismatch");
	end
endtask

task automatic report_timeout(input string what);
	$display("timeout while waiting for %s", what);
	$display("ERRORS FOUND");
	$fatal(1, "simulation stopped");
endtask

task automatic load_expected();
	int fd;
	int n;
	string line;
	logic [7:0] kind;
	word_t a;
	word_t d;
	fd = $fopen("testbench/program_vectors.txt", "r");
	if (fd == 0) begin
		$display("could not open the vectors file");
		$display("ERRORS FOUND");
		$fatal(1, "no stimulus");
	end
	else begin
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 0 && $sscanf(line, "%c %h %h", kind, a, d) == 3
				&& kind == "W") begin
				exp_adr.push_back(a);
				exp_dat.push_back(d);
			end
		end
		$fclose(fd);
	end
endtask

// sampled on the rising edge, the memory changes it on the falling one
task automatic wait_for_write();
	int n;
	n = 0;
	@(posedge clk);
	while (!wr_valid && n < WAIT_LIMIT) begin
		@(posedge clk);
		n++;
	end
	if (!wr_valid)
		report_timeout("a bus write");
endtask

initial begin
	int n;
	clk = 1'b0;
	rst_i = 1'b1;
	load_expected();
	if (exp_adr.size() == 0) begin
		$display("the vectors file holds no expected writes");
		$display("ERRORS FOUND");
		$fatal(1, "no stimulus");
	end

	// bus stays idle while reset is held
	repeat (8) begin
		@(negedge clk);
		check_word("reset cyc_o", 32'd0, {31'd0, cpu_cyc});
		check_word("reset stb_o", 32'd0, {31'd0, cpu_stb});
		check_word("reset we_o", 32'd0, {31'd0, cpu_we});
	end
	rst_i = 1'b0;

	// first transfer reads the reset vector
	n = 0;
	while (!cpu_cyc && n < WAIT_LIMIT) begin
		@(negedge clk);
		n++;
	end
	if (!cpu_cyc)
		report_timeout("the reset vector fetch");
	check_word("vector address", RST_VECT, cpu_adr);
	check_word("vector we_o", 32'd0, {31'd0, cpu_we});

	for (int i = 0; i < exp_adr.size(); i++) begin
		wait_for_write();
		check_word($sformatf("write %0d address", i), exp_adr[i], wr_adr);
		check_word($sformatf("write %0d data", i), exp_dat[i], wr_dat);
		check_word($sformatf("write %0d sel_o", i), {28'd0, SEL_WORD}, {28'd0, wr_sel});
	end

	$display("NO ERRORS");
	$finish;
end

endmodule

`default_nettype wire

// ==== testbench/bus_memory.sv ====
`default_nettype none

module bus_memory import cpu_pkg::*; (
	input wire logic clk,
	input wire logic cyc_i,
	input wire logic stb_i,
	input wire logic we_i,
	input wire sel_t sel_i,
	input wire word_t adr_i,
	input wire word_t dat_i,
	output logic ack_o,
	output word_t dat_o,
	// one pulse per completed write, stable around a rising edge
	output logic wr_valid_o,
	output word_t wr_adr_o,
	output word_t wr_dat_o,
	output sel_t wr_sel_o
);

timeunit 1ns;
timeprecision 100ps;

word_t mem [word_t];		// sparse memory image
int unsigned lcg_state;

function automatic int unsigned lcg_next();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return lcg_state >> 16;
endfunction

// ------------------------------------------------------------
// preload from the P lines of the vectors file
// ------------------------------------------------------------
task automatic load_image();
	int fd;
	int n;
	string line;
	logic [7:0] kind;
	word_t a;
	word_t d;
	fd = $fopen("testbench/program_vectors.txt", "r");
	if (fd != 0) begin
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 0 && $sscanf(line, "%c %h %h", kind, a, d) == 3 && kind == "P")
				mem[a] = d;
		end
		$fclose(fd);
	end
endtask

initial begin
	int unsigned delay;
	ack_o = 1'b0;
	dat_o = '0;
	wr_valid_o = 1'b0;
	wr_adr_o = '0;
	wr_dat_o = '0;
	wr_sel_o = '0;
	lcg_state = 32'd75388;
	load_image();
	forever begin
		@(negedge clk);
		if (cyc_i && stb_i) begin
			delay = lcg_next() % 4;	// 0 to 3 wait cycles
			repeat (delay) @(negedge clk);
			if (we_i) begin
				mem[adr_i] = dat_i;
				wr_adr_o = adr_i;
				wr_dat_o = dat_i;
				wr_sel_o = sel_i;
				wr_valid_o = 1'b1;
			end
			else begin
				dat_o = mem.exists(adr_i) ? mem[adr_i] : '0;
			end
			ack_o = 1'b1;
			@(negedge clk);
			ack_o = 1'b0;
			wr_valid_o = 1'b0;
		end
	end
end

endmodule

`default_nettype wire

// ==== verilog/cpu_top.sv ====
`default_nettype none

module cpu_top import cpu_pkg::*; (
	input wire logic clk,
	input wire logic rst_i,
	output logic cyc_o,
	output logic stb_o,
	output logic we_o,
	output sel_t sel_o,
	output word_t adr_o,
	output word_t dat_o,
	input wire logic ack_i,
	input wire word_t dat_i
);

// ------------------------------------------------------------
// internal links
// ------------------------------------------------------------
logic req, wr, done;
word_t req_adr, req_wdat, rdat;
reg_idx_t ra, rb, rt;
logic rf_we;
word_t rf_wd, rda, rdb;
alu_op_t alu_op;
word_t alu_a, alu_b, alu_res;
logic alu_c, alu_v, alu_z, alu_n;
logic flag_upd, arith, take_branch;
opcode_t opcode;

cpu_control u_ctrl (
	.clk(clk), .rst_i(rst_i), .done_i(done), .rdat_i(rdat),
	.rda_i(rda), .rdb_i(rdb), .alu_res_i(alu_res), .take_branch_i(take_branch),
	.req_o(req), .wr_o(wr), .adr_o(req_adr), .wdat_o(req_wdat),
	.ra_o(ra), .rb_o(rb), .rt_o(rt), .rf_we_o(rf_we), .rf_wd_o(rf_wd),
	.alu_op_o(alu_op), .a_o(alu_a), .b_o(alu_b),
	.flag_upd_o(flag_upd), .arith_o(arith), .opcode_o(opcode)
);

reg_file u_rf (
	.clk(clk), .rst_i(rst_i), .ra_i(ra), .rb_i(rb), .rt_i(rt),
	.we_i(rf_we), .wd_i(rf_wd), .rda_o(rda), .rdb_o(rdb)
);

alu u_alu (
	.op_i(alu_op), .a_i(alu_a), .b_i(alu_b), .res_o(alu_res),
	.c_o(alu_c), .v_o(alu_v), .z_o(alu_z), .n_o(alu_n)
);

status_flags u_flags (
	.clk(clk), .rst_i(rst_i), .upd_i(flag_upd), .arith_i(arith),
	.c_i(alu_c), .v_i(alu_v), .z_i(alu_z), .n_i(alu_n),
	.opcode_i(opcode), .take_branch_o(take_branch)
);

bus_master u_bus (
	.clk(clk), .rst_i(rst_i), .req_i(req), .wr_i(wr), .adr_i(req_adr),
	.wdat_i(req_wdat), .done_o(done), .rdat_o(rdat),
	.cyc_o(cyc_o), .stb_o(stb_o), .we_o(we_o), .sel_o(sel_o),
	.adr_o(adr_o), .dat_o(dat_o), .ack_i(ack_i), .dat_i(dat_i)
);

endmodule

`default_nettype wire

// ==== verilog/cpu_control.sv ====
`default_nettype none

module cpu_control import cpu_pkg::*; (
	input wire logic clk,
	input wire logic rst_i,
	input wire logic done_i,
	input wire word_t rdat_i,
	input wire word_t rda_i,
	input wire word_t rdb_i,
	input wire word_t alu_res_i,
	input wire logic take_branch_i,
	output logic req_o,
	output logic wr_o,
	output word_t adr_o,
	output word_t wdat_o,
	output reg_idx_t ra_o,
	output reg_idx_t rb_o,
	output reg_idx_t rt_o,
	output logic rf_we_o,
	output word_t rf_wd_o,
	output alu_op_t alu_op_o,
	output word_t a_o,
	output word_t b_o,
	output logic flag_upd_o,
	output logic arith_o,
	output opcode_t opcode_o
);

cpu_state_t state;
word_t pc;
word_t ir;
word_t ea;		// effective address for load and store
word_t st_dat;
word_t res;
word_t a_r;
word_t b_r;
word_t imm_sx;
imm_t imm;
opcode_t op;
alu_op_t alu_op;
logic bus_busy;		// request issued, waiting for done
logic use_imm;
logic is_ld;
logic is_st;
logic upd_fl;
logic is_arith;
logic wb_en;

// ------------------------------------------------------------
// instruction fields
// ------------------------------------------------------------
assign op = ir[7:0];
assign imm = ir[31:16];
assign imm_sx = {{16{imm[15]}}, imm};
assign use_imm = (op == OP_ADDI) || (op == OP_LDI);

assign ra_o = ir[15:12];
assign rb_o = (op == OP_ST) ? ir[11:8] : ir[19:16];	// store data comes from Rt
assign rt_o = ir[11:8];
assign opcode_o = op;

// bus requests
assign req_o = !bus_busy && (state == RESET1 || state == IFETCH
	|| state == LOAD || state == STORE);
assign wr_o = (state == STORE);
assign wdat_o = st_dat;

always_comb begin
	case (state)
	RESET1: adr_o = RST_VECT;
	IFETCH: adr_o = pc;
	default: adr_o = ea;
	endcase
end

assign alu_op_o = alu_op;
assign a_o = a_r;
assign b_o = b_r;
assign flag_upd_o = (state == EXEC) && upd_fl;
assign arith_o = is_arith;
assign rf_we_o = (state == WRITEBACK) && wb_en;
assign rf_wd_o = res;

// ------------------------------------------------------------
// sequencing
// ------------------------------------------------------------
always_ff @(posedge clk) begin
	if (rst_i) begin
		state <= RESET1;
		bus_busy <= 1'b0;
		pc <= '0;
		ir <= {24'h0, OP_NOP};
		alu_op <= ALU_PASS;
		is_ld <= 1'b0;
		is_st <= 1'b0;
		upd_fl <= 1'b0;
		is_arith <= 1'b0;
		wb_en <= 1'b0;
	end
	else begin
		if (req_o)
			bus_busy <= 1'b1;
		if (done_i)
			bus_busy <= 1'b0;
		case (state)
		RESET1: if (done_i) begin
			pc <= rdat_i;	// reset vector
			state <= IFETCH;
		end
		IFETCH: if (done_i) begin
			ir <= rdat_i;
			state <= DECODE;
		end
		DECODE: begin
			alu_op <= ALU_PASS;
			is_ld <= 1'b0;
			is_st <= 1'b0;
			upd_fl <= 1'b0;
			is_arith <= 1'b0;
			wb_en <= 1'b0;
			case (op)
			OP_ADD_RR, OP_ADDI: begin
				alu_op <= ALU_ADD;
				upd_fl <= 1'b1;
				is_arith <= 1'b1;
				wb_en <= 1'b1;
			end
			OP_SUB_RR, OP_CMP_RR: begin
				alu_op <= ALU_SUB;
				upd_fl <= 1'b1;
				is_arith <= 1'b1;
				wb_en <= (op == OP_SUB_RR);	// compare only sets flags
			end
			OP_AND_RR: begin
				alu_op <= ALU_AND;
				upd_fl <= 1'b1;
				wb_en <= 1'b1;
			end
			OP_OR_RR: begin
				alu_op <= ALU_OR;
				upd_fl <= 1'b1;
				wb_en <= 1'b1;
			end
			OP_EOR_RR: begin
				alu_op <= ALU_EOR;
				upd_fl <= 1'b1;
				wb_en <= 1'b1;
			end
			OP_LDI: wb_en <= 1'b1;
			OP_LD: begin
				is_ld <= 1'b1;
				wb_en <= 1'b1;
			end
			OP_ST: is_st <= 1'b1;
			default: ;	// branches and unknown opcodes
			endcase
			state <= EXEC;
		end
		EXEC: begin
			if (is_ld)
				state <= LOAD;
			else if (is_st)
				state <= STORE;
			else
				state <= WRITEBACK;
		end
		LOAD, STORE: if (done_i)
			state <= WRITEBACK;
		WRITEBACK: begin
			if (take_branch_i)
				pc <= pc + 32'd4 + imm_sx;
			else
				pc <= pc + 32'd4;
			state <= IFETCH;
		end
		default: state <= RESET1;
		endcase
	end
end

// operand, address and result registers
always_ff @(posedge clk) begin
	case (state)
	DECODE: begin
		a_r <= rda_i;
		b_r <= use_imm ? imm_sx : rdb_i;
		ea <= rda_i + imm_sx;
		st_dat <= rdb_i;
	end
	EXEC: res <= alu_res_i;
	LOAD: if (done_i) res <= rdat_i;
	default: ;
	endcase
end

endmodule

`default_nettype wire

// ==== verilog/bus_master.sv ====
`default_nettype none

module bus_master import cpu_pkg::*; (
	input wire logic clk,
	input wire logic rst_i,
	// request side, single-cycle strobes
	input wire logic req_i,
	input wire logic wr_i,
	input wire word_t adr_i,
	input wire word_t wdat_i,
	output logic done_o,
	output word_t rdat_o,
	// classic single-transfer bus
	output logic cyc_o,
	output logic stb_o,
	output logic we_o,
	output sel_t sel_o,
	output word_t adr_o,
	output word_t dat_o,
	input wire logic ack_i,
	input wire word_t dat_i
);

// ------------------------------------------------------------
// cycle control
// ------------------------------------------------------------
always_ff @(posedge clk) begin
	if (rst_i) begin
		cyc_o <= 1'b0;
		stb_o <= 1'b0;
		we_o <= 1'b0;
		sel_o <= '0;
		done_o <= 1'b0;
	end
	else begin
		done_o <= 1'b0;
		if (cyc_o) begin
			if (ack_i) begin	// end of transfer
				cyc_o <= 1'b0;
				stb_o <= 1'b0;
				we_o <= 1'b0;
				sel_o <= '0;
				done_o <= 1'b1;
			end
		end
		else if (req_i) begin
			cyc_o <= 1'b1;
			stb_o <= 1'b1;
			we_o <= wr_i;
			sel_o <= SEL_WORD;	// word transfers only
		end
	end
end

// address, write data and read data
always_ff @(posedge clk) begin
	if (!cyc_o && req_i) begin
		adr_o <= adr_i;
		dat_o <= wdat_i;
	end
	if (cyc_o && ack_i)
		rdat_o <= dat_i;
end

endmodule

`default_nettype wire

// ==== verilog/status_flags.sv ====
`default_nettype none

module status_flags import cpu_pkg::*; (
	input wire logic clk,
	input wire logic rst_i,
	input wire logic upd_i,
	input wire logic arith_i,
	input wire logic c_i,
	input wire logic v_i,
	input wire logic z_i,
	input wire logic n_i,
	input wire opcode_t opcode_i,
	output logic take_branch_o
);

logic nf, vf, zf, cf;

always_ff @(posedge clk) begin
	if (rst_i) begin
		nf <= 1'b0;
		vf <= 1'b0;
		zf <= 1'b0;
		cf <= 1'b0;
	end
	else if (upd_i) begin
		nf <= n_i;
		zf <= z_i;
		if (arith_i) begin	// logic ops keep c and v
			cf <= c_i;
			vf <= v_i;
		end
	end
end

// branch condition table
always_comb begin
	case (opcode_i)
	OP_ACBR: take_branch_o = 1'b0;
	OP_BEQ: take_branch_o = zf;
	OP_BNE: take_branch_o = !zf;
	OP_BPL: take_branch_o = !nf;
	OP_BMI: take_branch_o = nf;
	OP_BCS: take_branch_o = cf;
	OP_BCC: take_branch_o = !cf;
	OP_BVS: take_branch_o = vf;
	OP_BVC: take_branch_o = !vf;
	OP_BRA, OP_BRL: take_branch_o = 1'b1;
	OP_BHI: take_branch_o = cf & !zf;
	OP_BLS: take_branch_o = !cf | zf;
	OP_BGE: take_branch_o = (nf == vf);
	OP_BLT: take_branch_o = (nf != vf);
	OP_BGT: take_branch_o = (nf == vf) & !zf;
	OP_BLE: take_branch_o = zf | (nf != vf);
	default: take_branch_o = 1'b0;	// not a branch
	endcase
end

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
`default_nettype none

module alu import cpu_pkg::*; (
	input wire alu_op_t op_i,
	input wire word_t a_i,
	input wire word_t b_i,
	output word_t res_o,
	output logic c_o,
	output logic v_o,
	output logic z_o,
	output logic n_o
);

logic [WORD_W:0] sum;		// carry out in the top bit
logic [WORD_W:0] diff;		// top bit set means no borrow
logic is_sub;
logic ovf;

assign sum = {1'b0, a_i} + {1'b0, b_i};
assign diff = {1'b0, a_i} + {1'b0, ~b_i} + 1'b1;
assign is_sub = (op_i == ALU_SUB);

// ------------------------------------------------------------
// result select
// ------------------------------------------------------------
always_comb begin
	res_o = b_i;
	c_o = 1'b0;
	case (op_i)
	ALU_ADD: begin
		res_o = sum[WORD_W-1:0];
		c_o = sum[WORD_W];
	end
	ALU_SUB: begin
		res_o = diff[WORD_W-1:0];
		c_o = diff[WORD_W];
	end
	ALU_AND: res_o = a_i & b_i;
	ALU_OR: res_o = a_i | b_i;
	ALU_EOR: res_o = a_i ^ b_i;
	ALU_PASS: res_o = b_i;	// load immediate
	default: res_o = b_i;
	endcase
end

// signed overflow from the sign bits only
// add overflows when both signs agree and the result differs,
// subtract when the signs differ and the result follows b
assign ovf = (a_i[WORD_W-1] ^ res_o[WORD_W-1])
	& ~(a_i[WORD_W-1] ^ b_i[WORD_W-1] ^ is_sub);

assign v_o = (op_i == ALU_ADD || op_i == ALU_SUB) ? ovf : 1'b0;
assign z_o = (res_o == '0);
assign n_o = res_o[WORD_W-1];

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
`default_nettype none

module reg_file import cpu_pkg::*; (
	input wire logic clk,
	input wire logic rst_i,
	input wire reg_idx_t ra_i,
	input wire reg_idx_t rb_i,
	input wire reg_idx_t rt_i,
	input wire logic we_i,
	input wire word_t wd_i,
	output word_t rda_o,
	output word_t rdb_o
);

// register 0 has no storage
word_t regs [1:15];

always_ff @(posedge clk) begin
	if (rst_i) begin
		for (int i = 1; i < 16; i++)
			regs[i] <= '0;
	end
	else if (we_i && rt_i != '0) begin
		regs[rt_i] <= wd_i;
	end
end

// two asynchronous read ports
assign rda_o = (ra_i == '0) ? '0 : regs[ra_i];
assign rdb_o = (rb_i == '0) ? '0 : regs[rb_i];

endmodule

`default_nettype wire

// ==== verilog/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

// ------------------------------------------------------------
// widths and types
// ------------------------------------------------------------
localparam int WORD_W = 32;
localparam int RIDX_W = 4;

typedef logic [WORD_W-1:0] word_t;	// data, address and instruction word
typedef logic [RIDX_W-1:0] reg_idx_t;	// register number
typedef logic [7:0] opcode_t;
typedef logic [15:0] imm_t;
typedef logic [3:0] sel_t;		// byte lane select

// ------------------------------------------------------------
// opcodes
// ------------------------------------------------------------
localparam opcode_t OP_ADD_RR = 8'h01;
localparam opcode_t OP_SUB_RR = 8'h02;
localparam opcode_t OP_AND_RR = 8'h03;
localparam opcode_t OP_OR_RR = 8'h04;
localparam opcode_t OP_EOR_RR = 8'h05;
localparam opcode_t OP_CMP_RR = 8'h06;	// subtract, flags only
localparam opcode_t OP_ADDI = 8'h07;
localparam opcode_t OP_LDI = 8'h08;
localparam opcode_t OP_LD = 8'h09;
localparam opcode_t OP_ST = 8'h0A;
localparam opcode_t OP_NOP = 8'hEA;

// relative branches, 6502 style encodings where they exist
localparam opcode_t OP_BPL = 8'h10;
localparam opcode_t OP_BMI = 8'h30;
localparam opcode_t OP_BVC = 8'h50;
localparam opcode_t OP_BVS = 8'h70;
localparam opcode_t OP_BRA = 8'h80;
localparam opcode_t OP_BRL = 8'h82;
localparam opcode_t OP_BCC = 8'h90;
localparam opcode_t OP_BCS = 8'hB0;
localparam opcode_t OP_BNE = 8'hD0;
localparam opcode_t OP_BEQ = 8'hF0;
localparam opcode_t OP_BHI = 8'h13;
localparam opcode_t OP_BLS = 8'h33;
localparam opcode_t OP_ACBR = 8'h53;	// never taken
localparam opcode_t OP_BGE = 8'h93;
localparam opcode_t OP_BLT = 8'hB3;
localparam opcode_t OP_BGT = 8'hD3;
localparam opcode_t OP_BLE = 8'hF3;

localparam word_t RST_VECT = 32'hFFFFFFF0;	// holds the start address
localparam sel_t SEL_WORD = 4'hF;

typedef enum logic [2:0] {
	RESET1,
	IFETCH,
	DECODE,
	EXEC,
	LOAD,
	STORE,
	WRITEBACK
} cpu_state_t;

typedef enum logic [2:0] {
	ALU_ADD,
	ALU_SUB,
	ALU_AND,
	ALU_OR,
	ALU_EOR,
	ALU_PASS
} alu_op_t;

endpackage

`default_nettype wire
